//--- stm.f
logic/stm_pkg.sv
logic/stm_timer.sv
logic/stm_swapchain.sv
logic/stm_gain.sv
logic/stm_core.sv
logic/stm_top.sv
dv/stm_props.sv
dv/stm_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := stm_tb
FILELIST  := stm.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/stm_tb.sv
`timescale 1ns/100ps

module stm_tb import stm_pkg::*; ();

  localparam int ADDR_W = SEG_W + IDX_W + TRANS_W;

  logic                  CLK = 1'b0;
  logic                  arst_n;
  logic                  UPDATE;
  logic                  settings_update;
  logic [IDX_W-1:0]      cycle [NUM_SEGMENT];
  logic [DIV_W-1:0]      freq_div [NUM_SEGMENT];
  logic [SEG_W-1:0]      req_segment;
  transition_mode_e      transition_mode;
  logic [GPIO_SEL_W-1:0] transition_value;
  logic [REP_W-1:0]      rep;
  logic                  gpio_in [NUM_GPIO];
  logic                  wr_en;
  logic [SEG_W-1:0]      wr_segment;
  logic [IDX_W-1:0]      wr_idx;
  logic [TRANS_W-1:0]    wr_trans;
  logic [DATA_W-1:0]     wr_intensity;
  logic [DATA_W-1:0]     wr_phase;
  logic [DATA_W-1:0]     intensity;
  logic [DATA_W-1:0]     phase;
  logic                  dout_valid;
  logic [IDX_W-1:0]      debug_idx;
  logic [SEG_W-1:0]      debug_segment;
  logic [IDX_W-1:0]      debug_cycle;

  integer seed = 33;
  int     mismatch_cnt = 0;
  int     timeout_cnt = 0;

  // Reference model state
  logic [WORD_W-1:0]     shadow [NUM_SEGMENT * DEPTH * NUM_TRANS];
  logic [DIV_W-1:0]      m_presc [NUM_SEGMENT];
  logic [IDX_W-1:0]      m_tidx [NUM_SEGMENT];
  logic                  m_wrap [NUM_SEGMENT];
  logic                  m_upd;
  logic                  m_pend;
  logic                  m_stop;
  logic [SEG_W-1:0]      m_seg;
  logic [SEG_W-1:0]      m_req;
  transition_mode_e      m_mode;
  logic [GPIO_SEL_W-1:0] m_sel;
  logic [REP_W-1:0]      m_rep;
  logic [REP_W-1:0]      m_cnt;
  logic [SEG_W-1:0]      m_lseg;
  logic [IDX_W-1:0]      m_lidx;
  logic [IDX_W-1:0]      m_lcyc;

  stm_top stm_top_inst (.*);

  always #10 CLK = ~CLK;

  // ----------------------------------------
  // Cycle model of pacing, swap rules and UPDATE latch
  // ----------------------------------------
  always @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        m_presc[s] <= '0;
        m_tidx[s]  <= '0;
        m_wrap[s]  <= 1'b0;
      end
      m_upd  <= 1'b0;
      m_pend <= 1'b0;
      m_stop <= 1'b0;
      m_seg  <= '0;
      m_req  <= '0;
      m_mode <= TRANS_IMMEDIATE;
      m_sel  <= '0;
      m_rep  <= REP_INFINITE;
      m_cnt  <= '0;
      m_lseg <= '0;
      m_lidx <= '0;
      m_lcyc <= '0;
    end else begin
      m_upd <= settings_update;
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        m_wrap[s] <= 1'b0;
        if (settings_update) begin
          m_presc[s] <= '0;
          m_tidx[s]  <= '0;
        end else if (m_presc[s] != freq_div[s]) begin
          m_presc[s] <= m_presc[s] + 1'b1;
        end else begin
          m_presc[s] <= '0;
          m_tidx[s]  <= (m_tidx[s] == cycle[s]) ? IDX_W'(0) : m_tidx[s] + 1'b1;
          m_wrap[s]  <= (m_tidx[s] == cycle[s]);
        end
      end
      if (m_upd) begin
        m_rep  <= rep;
        m_cnt  <= '0;
        m_stop <= 1'b0;
        m_pend <= (req_segment != m_seg) && (transition_mode != TRANS_IMMEDIATE);
        m_req  <= req_segment;
        m_mode <= transition_mode;
        m_sel  <= transition_value;
        if (transition_mode == TRANS_IMMEDIATE) begin
          m_seg <= req_segment;
        end
      end else if (m_pend && ((m_mode == TRANS_SYNC_IDX) ? m_wrap[m_req] : gpio_in[m_sel])) begin
        m_seg  <= m_req;
        m_pend <= 1'b0;
        m_cnt  <= '0;
      end else begin
        if (m_wrap[m_seg] && (m_cnt != m_rep)) begin
          m_cnt <= m_cnt + 1'b1;
        end
        m_stop <= (m_rep != REP_INFINITE) && (m_cnt == m_rep);
      end
      if (UPDATE && !m_stop) begin
        m_lseg <= m_seg;
        m_lidx <= m_tidx[m_seg];
        m_lcyc <= cycle[m_seg];
      end
    end
  end

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic apply_settings(input int div0, input int div1, input int len0, input int len1,
                                input int seg, input transition_mode_e mode, input int sel,
                                input logic [REP_W-1:0] reps);
    freq_div[0]      = DIV_W'(div0);
    freq_div[1]      = DIV_W'(div1);
    cycle[0]         = IDX_W'(len0);
    cycle[1]         = IDX_W'(len1);
    req_segment      = SEG_W'(seg);
    transition_mode  = mode;
    transition_value = GPIO_SEL_W'(sel);
    rep              = reps;
    settings_update  = 1'b1;
    next_cycle();
    settings_update  = 1'b0;
    next_cycle();
  endtask

  // One UPDATE, then the latched debug state and the whole streamed frame
  task automatic play_frame();
    int                waited;
    logic [WORD_W-1:0] word;
    UPDATE = 1'b1;
    next_cycle();
    UPDATE = 1'b0;
    check_val("debug_idx", int'(debug_idx), int'(m_lidx));
    check_val("debug_segment", int'(debug_segment), int'(m_lseg));
    check_val("debug_cycle", int'(debug_cycle), int'(m_lcyc));
    waited = 0;
    while (!dout_valid && waited < 8) begin
      next_cycle();
      waited++;
    end
    if (!dout_valid) begin
      timeout_cnt++;
      $display("Timeout at %0t: dout_valid never rose after UPDATE", $time);
    end else begin
      for (int t = 0; t < NUM_TRANS; t++) begin
        word = shadow[{m_lseg, m_lidx, TRANS_W'(t)}];
        check_val("dout_valid", int'(dout_valid), 1);
        check_val("intensity", int'(intensity), int'(word[WORD_W-1:DATA_W]));
        check_val("phase", int'(phase), int'(word[DATA_W-1:0]));
        next_cycle();
      end
      check_val("dout_valid", int'(dout_valid), 0);
    end
  endtask

  initial begin
    logic [SEG_W-1:0] old_seg;
    logic [SEG_W-1:0] new_seg;
    logic [IDX_W-1:0] held_idx;
    int               sel;
    int               waited;
    arst_n           = 1'b0;
    UPDATE           = 1'b0;
    settings_update  = 1'b0;
    foreach (cycle[s]) cycle[s] = '0;
    foreach (freq_div[s]) freq_div[s] = '0;
    req_segment      = '0;
    transition_mode  = TRANS_IMMEDIATE;
    transition_value = '0;
    rep              = REP_INFINITE;
    foreach (gpio_in[g]) gpio_in[g] = 1'b0;
    wr_en            = 1'b0;
    wr_segment       = '0;
    wr_idx           = '0;
    wr_trans         = '0;
    wr_intensity     = '0;
    wr_phase         = '0;
    repeat (5) @(posedge CLK);
    #2;
    arst_n = 1'b1;

    // Fill both segments with random words
    wr_en = 1'b1;
    for (int a = 0; a < NUM_SEGMENT * DEPTH * NUM_TRANS; a++) begin
      {wr_segment, wr_idx, wr_trans} = ADDR_W'(a);
      wr_intensity = DATA_W'($random(seed));
      wr_phase     = DATA_W'($random(seed));
      shadow[a]    = {wr_intensity, wr_phase};
      next_cycle();
    end
    wr_en = 1'b0;

    // ----------------------------------------
    // Readout and index pacing under immediate swaps
    // ----------------------------------------
    repeat (4) begin
      apply_settings(rnd(4), rnd(4), rnd(DEPTH), rnd(DEPTH), rnd(NUM_SEGMENT),
                     TRANS_IMMEDIATE, 0, REP_INFINITE);
      repeat (6) begin
        repeat (rnd(20)) next_cycle();
        play_frame();
      end
    end

    // Swap on wrap of the requested segment
    old_seg = m_seg;
    new_seg = old_seg + 1'b1;
    apply_settings(rnd(3), rnd(3), rnd(8), rnd(8), int'(new_seg), TRANS_SYNC_IDX, 0,
                   REP_INFINITE);
    waited = 0;
    while (m_seg == old_seg && waited < 40) begin
      repeat (rnd(6)) next_cycle();
      play_frame();
      waited++;
    end
    if (m_seg == old_seg) begin
      timeout_cnt++;
      $display("Timeout at %0t: synchronised swap never happened", $time);
    end
    play_frame();
    check_val("debug_segment", int'(debug_segment), int'(new_seg));

    // Swap held off until the selected GPIO line goes high
    old_seg = m_seg;
    new_seg = old_seg + 1'b1;
    sel = rnd(NUM_GPIO);
    apply_settings(rnd(3), rnd(3), rnd(8), rnd(8), int'(new_seg), TRANS_GPIO, sel,
                   REP_INFINITE);
    // Every other line sits high and must not release the swap
    foreach (gpio_in[g]) gpio_in[g] = (g != sel);
    repeat (3) begin
      repeat (rnd(10)) next_cycle();
      play_frame();
      check_val("debug_segment", int'(debug_segment), int'(old_seg));
    end
    foreach (gpio_in[g]) gpio_in[g] = 1'b0;
    gpio_in[sel] = 1'b1;
    next_cycle();
    gpio_in[sel] = 1'b0;
    play_frame();
    check_val("debug_segment", int'(debug_segment), int'(new_seg));

    // ----------------------------------------
    // Repetition stop, then endless play
    // ----------------------------------------
    apply_settings(rnd(3), rnd(3), rnd(8), rnd(8), int'(m_seg), TRANS_IMMEDIATE, 0,
                   REP_W'(1 + rnd(3)));
    waited = 0;
    while (!m_stop && waited < 60) begin
      play_frame();
      waited++;
    end
    if (!m_stop) begin
      timeout_cnt++;
      $display("Timeout at %0t: playback never stopped after the repetitions", $time);
    end
    held_idx = m_lidx;
    old_seg  = m_lseg;
    repeat (4) begin
      repeat (rnd(20)) next_cycle();
      play_frame();
      check_val("debug_idx", int'(debug_idx), int'(held_idx));
      check_val("debug_segment", int'(debug_segment), int'(old_seg));
    end

    apply_settings(0, 0, DEPTH - 1, DEPTH - 1, int'(m_seg), TRANS_IMMEDIATE, 0, REP_INFINITE);
    play_frame();
    repeat (4) begin
      held_idx = debug_idx;
      repeat (rnd(20)) next_cycle();
      play_frame();
      assert (debug_idx != held_idx) else begin
        mismatch_cnt++;
        $display("Index stuck at %0d under endless repetition at %0t", debug_idx, $time);
      end
    end

    $display("Checks done with %0d mismatches and %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- dv/stm_props.sv
`timescale 1ns/100ps

module stm_props import stm_pkg::*; (
  input logic             CLK,
  input logic             arst_n,
  input logic             UPDATE,
  input logic             start,
  input logic             dout_valid,
  input logic             swap_stop,
  input logic [IDX_W-1:0] idx
);

  // ----------------------------------------
  // Start strobe and reader lead
  // ----------------------------------------
  start_follows_update: assert property (@(posedge CLK) disable iff (!arst_n)
    UPDATE |=> start)
    else $error("start did not rise one cycle after UPDATE");

  start_is_single: assert property (@(posedge CLK) disable iff (!arst_n)
    start |-> $past(UPDATE))
    else $error("start high without UPDATE on the previous cycle");

  valid_after_start: assert property (@(posedge CLK) disable iff (!arst_n)
    start |-> ##2 dout_valid)
    else $error("dout_valid not high two cycles after start");

  valid_rise_lead: assert property (@(posedge CLK) disable iff (!arst_n)
    $rose(dout_valid) |-> $past(start, 2))
    else $error("dout_valid rose without start two cycles earlier");

  // A stopped sequence never moves its index
  idx_held_on_stop: assert property (@(posedge CLK) disable iff (!arst_n)
    swap_stop |=> $stable(idx))
    else $error("idx changed while playback was stopped");

endmodule

bind stm_core stm_props stm_props_inst (
  .CLK        (CLK),
  .arst_n     (arst_n),
  .UPDATE     (UPDATE),
  .start      (start),
  .dout_valid (dout_valid),
  .swap_stop  (swap_stop),
  .idx        (idx)
);

//--- logic/stm_top.sv
`timescale 1ns/100ps

module stm_top import stm_pkg::*; (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  UPDATE,
  input  logic                  settings_update,
  input  logic [IDX_W-1:0]      cycle [NUM_SEGMENT],
  input  logic [DIV_W-1:0]      freq_div [NUM_SEGMENT],
  input  logic [SEG_W-1:0]      req_segment,
  input  transition_mode_e      transition_mode,
  input  logic [GPIO_SEL_W-1:0] transition_value,
  input  logic [REP_W-1:0]      rep,
  input  logic                  gpio_in [NUM_GPIO],
  input  logic                  wr_en,
  input  logic [SEG_W-1:0]      wr_segment,
  input  logic [IDX_W-1:0]      wr_idx,
  input  logic [TRANS_W-1:0]    wr_trans,
  input  logic [DATA_W-1:0]     wr_intensity,
  input  logic [DATA_W-1:0]     wr_phase,
  output logic [DATA_W-1:0]     intensity,
  output logic [DATA_W-1:0]     phase,
  output logic                  dout_valid,
  output logic [IDX_W-1:0]      debug_idx,
  output logic [SEG_W-1:0]      debug_segment,
  output logic [IDX_W-1:0]      debug_cycle
);

  logic [IDX_W-1:0] timer_idx [NUM_SEGMENT];
  logic             timer_wrap [NUM_SEGMENT];
  logic             update_settings;
  logic [SEG_W-1:0] swap_segment;
  logic             swap_stop;

  stm_timer stm_timer_inst (
    .CLK             (CLK),
    .arst_n          (arst_n),
    .settings_update (settings_update),
    .freq_div        (freq_div),
    .cycle           (cycle),
    .timer_idx       (timer_idx),
    .timer_wrap      (timer_wrap),
    .update_settings (update_settings)
  );

  stm_swapchain stm_swapchain_inst (
    .CLK              (CLK),
    .arst_n           (arst_n),
    .update_settings  (update_settings),
    .req_segment      (req_segment),
    .transition_mode  (transition_mode),
    .transition_value (transition_value),
    .rep              (rep),
    .timer_wrap       (timer_wrap),
    .gpio_in          (gpio_in),
    .segment          (swap_segment),
    .stop             (swap_stop)
  );

  // Start, index and segment toward the reader stay inside the core
  stm_core stm_core_inst (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .UPDATE        (UPDATE),
    .swap_segment  (swap_segment),
    .swap_stop     (swap_stop),
    .timer_idx     (timer_idx),
    .cycle         (cycle),
    .wr_en         (wr_en),
    .wr_segment    (wr_segment),
    .wr_idx        (wr_idx),
    .wr_trans      (wr_trans),
    .wr_intensity  (wr_intensity),
    .wr_phase      (wr_phase),
    .start         (),
    .idx           (),
    .segment       (),
    .intensity     (intensity),
    .phase         (phase),
    .dout_valid    (dout_valid),
    .debug_idx     (debug_idx),
    .debug_segment (debug_segment),
    .debug_cycle   (debug_cycle)
  );

endmodule

//--- logic/stm_core.sv
`timescale 1ns/100ps

module stm_core import stm_pkg::*; (
  input  logic               CLK,
  input  logic               arst_n,
  input  logic               UPDATE,
  input  logic [SEG_W-1:0]   swap_segment,
  input  logic               swap_stop,
  input  logic [IDX_W-1:0]   timer_idx [NUM_SEGMENT],
  input  logic [IDX_W-1:0]   cycle [NUM_SEGMENT],
  input  logic               wr_en,
  input  logic [SEG_W-1:0]   wr_segment,
  input  logic [IDX_W-1:0]   wr_idx,
  input  logic [TRANS_W-1:0] wr_trans,
  input  logic [DATA_W-1:0]  wr_intensity,
  input  logic [DATA_W-1:0]  wr_phase,
  output logic               start,
  output logic [IDX_W-1:0]   idx,
  output logic [SEG_W-1:0]   segment,
  output logic [DATA_W-1:0]  intensity,
  output logic [DATA_W-1:0]  phase,
  output logic               dout_valid,
  output logic [IDX_W-1:0]   debug_idx,
  output logic [SEG_W-1:0]   debug_segment,
  output logic [IDX_W-1:0]   debug_cycle
);

  logic [IDX_W-1:0] cycle_q;

  // A stopped sequence keeps replaying the last latched frame
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      start   <= 1'b0;
      idx     <= '0;
      segment <= '0;
      cycle_q <= '0;
    end else begin
      start <= UPDATE;
      if (UPDATE && !swap_stop) begin
        segment <= swap_segment;
        idx     <= timer_idx[swap_segment];
        cycle_q <= cycle[swap_segment];
      end
    end
  end

  assign debug_idx     = idx;
  assign debug_segment = segment;
  assign debug_cycle   = cycle_q;

  stm_gain stm_gain_inst (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .start        (start),
    .segment      (segment),
    .idx          (idx),
    .wr_en        (wr_en),
    .wr_segment   (wr_segment),
    .wr_idx       (wr_idx),
    .wr_trans     (wr_trans),
    .wr_intensity (wr_intensity),
    .wr_phase     (wr_phase),
    .intensity    (intensity),
    .phase        (phase),
    .dout_valid   (dout_valid)
  );

endmodule

//--- logic/stm_gain.sv
`timescale 1ns/100ps

module stm_gain import stm_pkg::*; (
  input  logic              CLK,
  input  logic              arst_n,
  input  logic              start,
  input  logic [SEG_W-1:0]  segment,
  input  logic [IDX_W-1:0]  idx,
  input  logic              wr_en,
  input  logic [SEG_W-1:0]  wr_segment,
  input  logic [IDX_W-1:0]  wr_idx,
  input  logic [TRANS_W-1:0] wr_trans,
  input  logic [DATA_W-1:0] wr_intensity,
  input  logic [DATA_W-1:0] wr_phase,
  output logic [DATA_W-1:0] intensity,
  output logic [DATA_W-1:0] phase,
  output logic              dout_valid
);

  logic [WORD_W-1:0] mem [NUM_SEGMENT * DEPTH * NUM_TRANS];
  logic [WORD_W-1:0] rd_data;

  reader_state_e      state;
  logic [TRANS_W-1:0] trans_cnt;
  logic [SEG_W-1:0]   seg_q;
  logic [IDX_W-1:0]   idx_q;

  // Host write port, address is segment, index, transducer from high to low
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[{wr_segment, wr_idx, wr_trans}] <= {wr_intensity, wr_phase};
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      seg_q <= segment;
      idx_q <= idx;
    end
    rd_data <= mem[{seg_q, idx_q, trans_cnt}];
  end

  // Walks transducers 0 to NUM_TRANS-1, a fresh start always begins again at 0
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state      <= READER_IDLE;
      trans_cnt  <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= (state == READER_STREAM);
      if (start) begin
        state     <= READER_STREAM;
        trans_cnt <= '0;
      end else if (state == READER_STREAM) begin
        if (trans_cnt == TRANS_W'(NUM_TRANS - 1)) begin
          state <= READER_IDLE;
        end
        trans_cnt <= trans_cnt + 1'b1;
      end
    end
  end

  assign intensity = rd_data[WORD_W-1:DATA_W];
  assign phase     = rd_data[DATA_W-1:0];

endmodule

//--- logic/stm_swapchain.sv
`timescale 1ns/100ps

module stm_swapchain import stm_pkg::*; (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  update_settings,
  input  logic [SEG_W-1:0]      req_segment,
  input  transition_mode_e      transition_mode,
  input  logic [GPIO_SEL_W-1:0] transition_value,
  input  logic [REP_W-1:0]      rep,
  input  logic                  timer_wrap [NUM_SEGMENT],
  input  logic                  gpio_in [NUM_GPIO],
  output logic [SEG_W-1:0]      segment,
  output logic                  stop
);

  logic                  pending;
  logic [SEG_W-1:0]      req_seg_q;
  transition_mode_e      mode_q;
  logic [GPIO_SEL_W-1:0] gpio_sel_q;
  logic [REP_W-1:0]      rep_q;
  logic [REP_W-1:0]      rep_cnt;
  logic                  switch_now;

  // ----------------------------------------
  // Deferred switch condition
  // ----------------------------------------
  always_comb begin
    switch_now = 1'b0;
    if (pending) begin
      case (mode_q)
        TRANS_SYNC_IDX: switch_now = timer_wrap[req_seg_q];
        TRANS_GPIO:     switch_now = gpio_in[gpio_sel_q];
        default:        switch_now = 1'b1;
      endcase
    end
  end

  // ----------------------------------------
  // Segment select and loop counting
  // ----------------------------------------
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      segment    <= '0;
      stop       <= 1'b0;
      pending    <= 1'b0;
      req_seg_q  <= '0;
      mode_q     <= TRANS_IMMEDIATE;
      gpio_sel_q <= '0;
      rep_q      <= REP_INFINITE;
      rep_cnt    <= '0;
    end else if (update_settings) begin
      rep_q   <= rep;
      rep_cnt <= '0;
      stop    <= 1'b0;
      if (req_segment == segment) begin
        pending <= 1'b0;
      end else if (transition_mode == TRANS_IMMEDIATE) begin
        segment <= req_segment;
        pending <= 1'b0;
      end else begin
        pending    <= 1'b1;
        req_seg_q  <= req_segment;
        mode_q     <= transition_mode;
        gpio_sel_q <= transition_value;
      end
    end else if (switch_now) begin
      segment <= req_seg_q;
      pending <= 1'b0;
      rep_cnt <= '0;
    end else begin
      // Counter saturates at rep so stop stays high until the next settings update
      if (timer_wrap[segment] && (rep_cnt != rep_q)) begin
        rep_cnt <= rep_cnt + 1'b1;
      end
      stop <= (rep_q != REP_INFINITE) && (rep_cnt == rep_q);
    end
  end

endmodule

//--- logic/stm_timer.sv
`timescale 1ns/100ps

module stm_timer import stm_pkg::*; (
  input  logic             CLK,
  input  logic             arst_n,
  input  logic             settings_update,
  input  logic [DIV_W-1:0] freq_div [NUM_SEGMENT],
  input  logic [IDX_W-1:0] cycle [NUM_SEGMENT],
  output logic [IDX_W-1:0] timer_idx [NUM_SEGMENT],
  output logic             timer_wrap [NUM_SEGMENT],
  output logic             update_settings
);

  logic [DIV_W-1:0] presc [NUM_SEGMENT];

  // Both segments restart on the same edge so their indices stay in phase
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      update_settings <= 1'b0;
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        presc[s]      <= '0;
        timer_idx[s]  <= '0;
        timer_wrap[s] <= 1'b0;
      end
    end else begin
      update_settings <= settings_update;
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        if (settings_update) begin
          presc[s]      <= '0;
          timer_idx[s]  <= '0;
          timer_wrap[s] <= 1'b0;
        end else if (presc[s] == freq_div[s]) begin
          presc[s] <= '0;
          // An index past cycle can only appear after cycle shrinks, so fold it back too
          if (timer_idx[s] >= cycle[s]) begin
            timer_idx[s]  <= '0;
            timer_wrap[s] <= 1'b1;
          end else begin
            timer_idx[s]  <= timer_idx[s] + 1'b1;
            timer_wrap[s] <= 1'b0;
          end
        end else begin
          presc[s]      <= presc[s] + 1'b1;
          timer_wrap[s] <= 1'b0;
        end
      end
    end
  end

endmodule

//--- logic/stm_pkg.sv
package stm_pkg;

  // ----------------------------------------
  // Array and pattern geometry
  // ----------------------------------------
  localparam int NUM_SEGMENT = 2;
  localparam int SEG_W = $clog2(NUM_SEGMENT);

  localparam int NUM_TRANS = 8;
  localparam int TRANS_W = $clog2(NUM_TRANS);

  localparam int IDX_W = 6;
  localparam int DEPTH = 64;

  // Pattern word holds intensity in the upper byte and phase in the lower
  localparam int DATA_W = 8;
  localparam int WORD_W = 2 * DATA_W;

  // ----------------------------------------
  // Pacing and playback control
  // ----------------------------------------
  localparam int DIV_W = 16;
  localparam int REP_W = 16;
  localparam logic [REP_W-1:0] REP_INFINITE = '1;

  localparam int NUM_GPIO = 4;
  localparam int GPIO_SEL_W = $clog2(NUM_GPIO);

  typedef enum logic [1:0] {
    TRANS_IMMEDIATE = 2'd0,
    TRANS_SYNC_IDX  = 2'd1,
    TRANS_GPIO      = 2'd2
  } transition_mode_e;

  typedef enum logic {
    READER_IDLE   = 1'b0,
    READER_STREAM = 1'b1
  } reader_state_e;

endpackage
